//--- files.f
engine_pkg.sv
sync_fifo.sv
cmd_decoder.sv
operand_buffer.sv
dot_mac.sv
engine_top.sv
tb_checker.sv
tb_engine.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_engine -Mdir obj_dir -f files.f
	@out=$$(./obj_dir/Vtb_engine); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- tb_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_engine
    import engine_pkg::*;
();

    // Roughly 75 jobs of at most 67 cycles, about 1100 load words
    // and the back-pressure hold, with plenty of margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int BP_JOBS        = 20;
    // Longest job from start to done, plus a cycle of issue
    localparam int MAX_JOB_CYCLES = OPERAND_DEPTH + 3;

    logic      clk;
    logic      rst;
    cmd_word_t cmd_wdata;
    logic      cmd_wen;
    logic      cmd_full;
    result_t   result_data;
    logic      result_ren;
    logic      result_empty;
    logic      busy;
    opcode_t   last_opcode;
    logic      exp_push;
    result_t   exp_value;

    // Shadow copy of both operand banks
    op_word_t  shadow_left  [OPERAND_DEPTH];
    op_word_t  shadow_right [OPERAND_DEPTH];

    integer    seed = 9;
    int        cycle_count = 0;
    int        tb_errors = 0;
    int        errors_before = 0;
    int        checked;
    int        chk_errors;
    int        pending;

    engine_top dut (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_cmd_wdata    (cmd_wdata),
        .i_cmd_wen      (cmd_wen),
        .o_cmd_full     (cmd_full),
        .o_result_data  (result_data),
        .i_result_ren   (result_ren),
        .o_result_empty (result_empty),
        .o_busy         (busy),
        .o_last_opcode  (last_opcode)
    );

    tb_checker u_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_exp_push     (exp_push),
        .i_exp_value    (exp_value),
        .i_result_empty (result_empty),
        .i_result_ren   (result_ren),
        .i_result_data  (result_data),
        .o_checked      (checked),
        .o_errors       (chk_errors),
        .o_pending      (pending)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ====================
    // Reference model
    // ====================
    // Sum of lane products over the words, clamped to 16 bits signed
    // Addresses wrap inside the 64-word banks
    function automatic result_t dot_reference(input word_addr_t left,
                                              input word_addr_t right,
                                              input word_addr_t len_m1);
        int         sum = 0;
        word_addr_t a_l;
        word_addr_t a_r;
        for (int w = 0; w <= int'(len_m1); w++) begin
            a_l = left + word_addr_t'(w);
            a_r = right + word_addr_t'(w);
            for (int k = 0; k < LANES; k++) begin
                sum += int'($signed(shadow_left[a_l][8*k +: 8])) *
                       int'($signed(shadow_right[a_r][8*k +: 8]));
            end
        end
        if (sum > 32767) begin
            return 16'sh7FFF;
        end else if (sum < -32768) begin
            return 16'sh8000;
        end
        return result_t'(sum);
    endfunction

    // ====================
    // Stimulus tasks
    // ====================
    // All tasks start and end on a falling edge
    task automatic push_cmd(input cmd_word_t word);
        while (cmd_full) begin
            @(negedge clk);
        end
        cmd_wdata = word;
        cmd_wen   = 1'b1;
        @(negedge clk);
        cmd_wen   = 1'b0;
    endtask

    // Header then data word
    // Shadow copy follows the DUT bank
    task automatic load_word(input logic target, input word_addr_t addr, input op_word_t data);
        push_cmd({OP_LOAD, target, 5'd0, addr, 16'd0});
        push_cmd(data);
        if (target) begin
            shadow_right[addr] = data;
        end else begin
            shadow_left[addr] = data;
        end
    endtask

    task automatic fill_banks(input bit random_fill, input op_word_t left_val,
                              input op_word_t right_val);
        for (int a = 0; a < OPERAND_DEPTH; a++) begin
            if (random_fill) begin
                left_val  = $random(seed);
                right_val = $random(seed);
            end
            load_word(1'b0, word_addr_t'(a), left_val);
            load_word(1'b1, word_addr_t'(a), right_val);
        end
    endtask

    // DOT command plus its expected value for the checker
    task automatic issue_dot(input word_addr_t left, input word_addr_t right,
                             input word_addr_t len_m1);
        push_cmd({OP_DOT, left, right, 10'd0, len_m1});
        exp_value = dot_reference(left, right, len_m1);
        exp_push  = 1'b1;
        @(negedge clk);
        exp_push  = 1'b0;
    endtask

    task automatic issue_random_dot();
        word_addr_t left;
        word_addr_t right;
        word_addr_t len_m1;
        left   = word_addr_t'($random(seed));
        right  = word_addr_t'($random(seed));
        len_m1 = word_addr_t'($random(seed));
        issue_dot(left, right, len_m1);
    endtask

    // Pop results as they show up; the checker compares them
    task automatic read_results(input int count);
        for (int i = 0; i < count; i++) begin
            while (result_empty) begin
                @(negedge clk);
            end
            result_ren = 1'b1;
            @(negedge clk);
            result_ren = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_errors + chk_errors;
        if (errs == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errs - errors_before);
        end
        errors_before = errs;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst        = 1'b1;
        cmd_wdata  = '0;
        cmd_wen    = 1'b0;
        result_ren = 1'b0;
        exp_push   = 1'b0;
        exp_value  = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        check_value("o_result_empty after reset", result_empty, 1);
        check_value("o_busy after reset", busy, 0);
        check_value("o_cmd_full after reset", cmd_full, 0);
        finish_test("reset state");

        // Mixed signs, including both extremes of a lane
        load_word(1'b0, 6'd0, 32'h0102_0304);
        load_word(1'b0, 6'd1, 32'hFF7F_8001);
        load_word(1'b1, 6'd10, 32'h0506_0708);
        load_word(1'b1, 6'd11, 32'h02FE_0281);
        issue_dot(6'd0, 6'd10, 6'd1);
        read_results(1);
        finish_test("single dot");

        // Batches of five stay well below the result FIFO depth
        fill_banks(1'b1, '0, '0);
        for (int round = 0; round < 10; round++) begin
            for (int j = 0; j < 5; j++) begin
                issue_random_dot();
            end
            read_results(5);
        end
        finish_test("random dots");

        fill_banks(1'b0, 32'h7F7F_7F7F, 32'h7F7F_7F7F);
        issue_dot(6'd0, 6'd0, 6'd63);
        fill_banks(1'b0, 32'h7F7F_7F7F, 32'h8080_8080);
        issue_dot(6'd0, 6'd0, 6'd63);
        read_results(2);
        finish_test("saturation");

        // Results pile up until the FIFO fills and DOT issue stalls
        fill_banks(1'b1, '0, '0);
        for (int j = 0; j < BP_JOBS; j++) begin
            issue_random_dot();
        end
        repeat (RES_FIFO_DEPTH * MAX_JOB_CYCLES) @(negedge clk);
        check_value("o_busy with the result FIFO full", busy, 1);
        read_results(BP_JOBS);
        check_value("o_busy after the last job", busy, 0);
        check_value("o_result_empty after the last job", result_empty, 1);
        finish_test("back-pressure");

        // Unknown opcode retires after the DOT ahead of it
        issue_dot(6'd5, 6'd9, 6'd3);
        push_cmd({4'hA, 28'h123_4567});
        read_results(1);
        wait_idle();
        check_value("o_last_opcode after unknown opcode", last_opcode, 4'hA);
        push_cmd('0);
        wait_idle();
        check_value("o_last_opcode after NOP", last_opcode, OP_NOP);
        check_value("o_result_empty after NOP", result_empty, 1);
        finish_test("nop and unknown opcode");

        if (pending != 0) begin
            $display("Error: %0d expected results never came out", pending);
            tb_errors++;
        end
        $display("Summary: %0d results checked, %0d errors", checked, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_engine

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import engine_pkg::*;
(
    input  wire     i_clk,
    input  wire     i_rst,
    // Expected values, one per DOT in command order
    input  wire     i_exp_push,
    input  result_t i_exp_value,
    // Result side of the DUT
    input  wire     i_result_empty,
    input  wire     i_result_ren,
    input  result_t i_result_data,
    // Running counts
    output int      o_checked,
    output int      o_errors,
    output int      o_pending
);

    result_t exp_q [$];
    result_t expected;
    int      checked = 0;
    int      errors  = 0;
    int      pending = 0;

    assign o_checked = checked;
    assign o_errors  = errors;
    assign o_pending = pending;

    // ====================
    // Compare on each pop
    // ====================
    // A pop is a read strobe while the FIFO shows a head word
    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (i_result_ren && !i_result_empty) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: result %0d came out with no expected value waiting",
                             $time, i_result_data);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    checked++;
                    if (i_result_data !== expected) begin
                        $display("Mismatch at %0t: result %0d expected %0d, got %0d",
                                 $time, checked, expected, i_result_data);
                        errors++;
                    end
                end
            end
            // New expectations join behind the ones already waiting
            if (i_exp_push) begin
                exp_q.push_back(i_exp_value);
            end
            pending = exp_q.size();
        end
    end

endmodule : tb_checker

`default_nettype wire

//--- engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module engine_top
    import engine_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst,
    // ====================
    // Host command side
    // ====================
    input  cmd_word_t i_cmd_wdata,
    input  wire       i_cmd_wen,
    output logic      o_cmd_full,
    // ====================
    // Host result side
    // ====================
    output result_t   o_result_data,
    input  wire       i_result_ren,
    output logic      o_result_empty,
    // Status
    output logic      o_busy,
    output opcode_t   o_last_opcode
);

    // Command FIFO to decoder
    cmd_word_t              cmd_head;
    logic                   cmd_empty;
    logic                   cmd_pop;
    logic [CMD_CNT_W-1:0]   cmd_count;

    // Decoder to buffer and MAC
    load_req_t  load_req;
    logic       dot_start;
    dot_job_t   dot_job;
    logic       dot_done;
    logic       dec_busy;

    // MAC to buffer and result FIFO
    logic       rd_en;
    word_addr_t rd_addr_left;
    word_addr_t rd_addr_right;
    op_word_t   left_word;
    op_word_t   right_word;
    logic       res_wen;
    result_t    res_data;
    logic       res_full;
    logic       mac_busy;

    sync_fifo #(
        .WIDTH   ($bits(cmd_word_t)),
        .DEPTH   (CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wdata (i_cmd_wdata),
        .i_wen   (i_cmd_wen),
        .o_full  (o_cmd_full),
        .o_rdata (cmd_head),
        .i_ren   (cmd_pop),
        .o_empty (cmd_empty),
        .o_count (cmd_count)
    );

    cmd_decoder u_decoder (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cmd         (cmd_head),
        .i_cmd_empty   (cmd_empty),
        .o_cmd_pop     (cmd_pop),
        .i_res_full    (res_full),
        .o_load        (load_req),
        .o_dot_start   (dot_start),
        .o_dot_job     (dot_job),
        .i_dot_done    (dot_done),
        .o_busy        (dec_busy),
        .o_last_opcode (o_last_opcode)
    );

    operand_buffer u_operands (
        .i_clk           (i_clk),
        .i_load          (load_req),
        .i_rd_en         (rd_en),
        .i_rd_addr_left  (rd_addr_left),
        .i_rd_addr_right (rd_addr_right),
        .o_left_word     (left_word),
        .o_right_word    (right_word)
    );

    dot_mac u_mac (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_start         (dot_start),
        .i_job           (dot_job),
        .o_rd_en         (rd_en),
        .o_rd_addr_left  (rd_addr_left),
        .o_rd_addr_right (rd_addr_right),
        .i_left_word     (left_word),
        .i_right_word    (right_word),
        .o_res_wen       (res_wen),
        .o_res_data      (res_data),
        .o_done          (dot_done),
        .o_busy          (mac_busy)
    );

    // Host pops results from here
    sync_fifo #(
        .WIDTH   ($bits(result_t)),
        .DEPTH   (RES_FIFO_DEPTH)
    ) u_result_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wdata (res_data),
        .i_wen   (res_wen),
        .o_full  (res_full),
        .o_rdata (o_result_data),
        .i_ren   (i_result_ren),
        .o_empty (o_result_empty),
        .o_count ()
    );

    // Busy while commands wait or a job is in flight
    assign o_busy = (cmd_count != '0) || dec_busy || mac_busy;

endmodule : engine_top

`default_nettype wire

//--- dot_mac.sv
`timescale 1ns/1ps
`default_nettype none

module dot_mac
    import engine_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,
    // Job from the decoder
    input  wire        i_start,
    input  dot_job_t   i_job,
    // Operand buffer reads
    output logic       o_rd_en,
    output word_addr_t o_rd_addr_left,
    output word_addr_t o_rd_addr_right,
    input  op_word_t   i_left_word,
    input  op_word_t   i_right_word,
    // Result write
    output logic       o_res_wen,
    output result_t    o_res_data,
    // Status
    output logic       o_done,
    output logic       o_busy
);

    mac_state_t state;
    word_addr_t addr_l;
    word_addr_t addr_r;
    word_addr_t remaining;
    logic       rd_vld;
    acc_t       acc;
    acc_t       lane_sum;

    // Reads run in the N cycles after start
    assign o_rd_en         = (state == MAC_READ);
    assign o_rd_addr_left  = addr_l;
    assign o_rd_addr_right = addr_r;

    // Result and done land N+2 cycles after start
    assign o_res_wen = (state == MAC_DONE);
    assign o_done    = (state == MAC_DONE);
    assign o_busy    = (state != MAC_IDLE);

    // Four signed lane products, widened before the multiply
    always_comb begin
        lane_sum = '0;
        for (int k = 0; k < LANES; k++) begin
            lane_sum = lane_sum +
                acc_t'(elem_t'(i_left_word[k*ELEM_W +: ELEM_W])) *
                acc_t'(elem_t'(i_right_word[k*ELEM_W +: ELEM_W]));
        end
    end

    // Clamp to the signed 16-bit range
    always_comb begin
        if (acc > RES_MAX) begin
            o_res_data = RES_MAX[RES_W-1:0];
        end else if (acc < RES_MIN) begin
            o_res_data = RES_MIN[RES_W-1:0];
        end else begin
            o_res_data = acc[RES_W-1:0];
        end
    end

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= MAC_IDLE;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= o_rd_en;
            case (state)
                MAC_IDLE:  if (i_start) state <= MAC_READ;
                MAC_READ:  if (remaining == '0) state <= MAC_DRAIN;
                // Last word comes back here
                MAC_DRAIN: state <= MAC_DONE;
                MAC_DONE:  state <= MAC_IDLE;
                default:   state <= MAC_IDLE;
            endcase
        end
    end

    // Address counters and accumulator
    always_ff @(posedge i_clk) begin
        if (state == MAC_IDLE && i_start) begin
            addr_l    <= i_job.left;
            addr_r    <= i_job.right;
            remaining <= i_job.len_m1;
            acc       <= '0;
        end else begin
            if (o_rd_en) begin
                addr_l    <= addr_l + 1'b1;
                addr_r    <= addr_r + 1'b1;
                remaining <= remaining - 1'b1;
            end
            if (rd_vld) begin
                acc <= acc + lane_sum;
            end
        end
    end

endmodule : dot_mac

`default_nettype wire

//--- operand_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_buffer
    import engine_pkg::*;
(
    input  wire        i_clk,
    // Write port shared by both banks
    input  load_req_t  i_load,
    // Read port, one address per bank
    input  wire        i_rd_en,
    input  word_addr_t i_rd_addr_left,
    input  word_addr_t i_rd_addr_right,
    output op_word_t   o_left_word,
    output op_word_t   o_right_word
);

    // Each word packs four elements, byte k is lane k
    op_word_t left_mem  [OPERAND_DEPTH];
    op_word_t right_mem [OPERAND_DEPTH];

    // ====================
    // Bank writes
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_load.valid && !i_load.target) begin
            left_mem[i_load.addr] <= i_load.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load.valid && i_load.target) begin
            right_mem[i_load.addr] <= i_load.data;
        end
    end

    // ====================
    // Registered reads
    // ====================
    // Data is valid the cycle after i_rd_en
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_left_word  <= left_mem[i_rd_addr_left];
            o_right_word <= right_mem[i_rd_addr_right];
        end
    end

endmodule : operand_buffer

`default_nettype wire

//--- cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import engine_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst,
    // Command FIFO head
    input  cmd_word_t i_cmd,
    input  wire       i_cmd_empty,
    output logic      o_cmd_pop,
    // Result FIFO back-pressure
    input  wire       i_res_full,
    // Operand buffer write
    output load_req_t o_load,
    // MAC job
    output logic      o_dot_start,
    output dot_job_t  o_dot_job,
    input  wire       i_dot_done,
    // Status
    output logic      o_busy,
    output opcode_t   o_last_opcode
);

    dec_state_t state;
    opcode_t    opcode;
    // Pending LOAD header, held until its data word shows up
    logic       ld_target;
    word_addr_t ld_addr;

    assign opcode = i_cmd[31:28];
    assign o_busy = (state != DEC_IDLE);

    // DOT fields straight from the head word
    assign o_dot_job.left   = i_cmd[27:22];
    assign o_dot_job.right  = i_cmd[21:16];
    assign o_dot_job.len_m1 = i_cmd[5:0];

    // ====================
    // Pop and issue
    // ====================
    always_comb begin
        o_cmd_pop     = 1'b0;
        o_dot_start   = 1'b0;
        o_load.valid  = 1'b0;
        o_load.target = ld_target;
        o_load.addr   = ld_addr;
        o_load.data   = i_cmd;
        case (state)
            DEC_IDLE: begin
                if (!i_cmd_empty) begin
                    if (opcode == OP_DOT) begin
                        // Hold the DOT until the result has a slot
                        o_cmd_pop   = !i_res_full;
                        o_dot_start = !i_res_full;
                    end else begin
                        o_cmd_pop = 1'b1;
                    end
                end
            end
            DEC_LOAD_DATA: begin
                // Data word goes to the bank in the cycle it is popped
                if (!i_cmd_empty) begin
                    o_cmd_pop    = 1'b1;
                    o_load.valid = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // ====================
    // State register
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= DEC_IDLE;
            o_last_opcode <= OP_NOP;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (o_cmd_pop) begin
                        case (opcode)
                            OP_LOAD: state <= DEC_LOAD_DATA;
                            OP_DOT:  state <= DEC_WAIT_DOT;
                            // NOP and unknown opcodes retire here
                            default: o_last_opcode <= opcode;
                        endcase
                    end
                end
                DEC_LOAD_DATA: begin
                    if (o_cmd_pop) begin
                        state         <= DEC_IDLE;
                        o_last_opcode <= OP_LOAD;
                    end
                end
                DEC_WAIT_DOT: begin
                    if (i_dot_done) begin
                        state         <= DEC_IDLE;
                        o_last_opcode <= OP_DOT;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // Header capture
    always_ff @(posedge i_clk) begin
        if (state == DEC_IDLE && o_cmd_pop && opcode == OP_LOAD) begin
            ld_target <= i_cmd[27];
            ld_addr   <= i_cmd[21:16];
        end
    end

endmodule : cmd_decoder

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire                          i_clk,
    input  wire                          i_rst,
    // Write side
    input  wire  [WIDTH-1:0]             i_wdata,
    input  wire                          i_wen,
    output logic                         o_full,
    // Read side, head shown without a read cycle
    output logic [WIDTH-1:0]             o_rdata,
    input  wire                          i_ren,
    output logic                         o_empty,
    output logic [$clog2(DEPTH+1)-1:0]   o_count
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // Writes on full and reads on empty are dropped
    assign do_wr = i_wen && !o_full;
    assign do_rd = i_ren && !o_empty;

    assign o_full  = (o_count == DEPTH);
    assign o_empty = (o_count == '0);
    assign o_rdata = mem[rd_ptr];

    // Storage
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    // Pointers wrap at DEPTH-1, so any depth works
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count moves only when exactly one side acts
            if (do_wr && !do_rd) begin
                o_count <= o_count + 1'b1;
            end else if (do_rd && !do_wr) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

endmodule : sync_fifo

`default_nettype wire

//--- engine_pkg.sv
`default_nettype none

package engine_pkg;

    // ====================
    // Widths and depths
    // ====================
    localparam int CMD_W          = 32;
    localparam int OPCODE_W       = 4;
    localparam int ADDR_W         = 6;
    localparam int ELEM_W         = 8;
    localparam int LANES          = 4;
    localparam int WORD_W         = ELEM_W * LANES;
    localparam int ACC_W          = 32;
    localparam int RES_W          = 16;
    localparam int OPERAND_DEPTH  = 64;
    localparam int CMD_FIFO_DEPTH = 16;
    localparam int RES_FIFO_DEPTH = 16;
    // Occupancy counter of the command FIFO
    localparam int CMD_CNT_W      = $clog2(CMD_FIFO_DEPTH + 1);

    typedef logic        [CMD_W-1:0]    cmd_word_t;
    typedef logic        [OPCODE_W-1:0] opcode_t;
    typedef logic        [ADDR_W-1:0]   word_addr_t;
    typedef logic        [WORD_W-1:0]   op_word_t;
    typedef logic signed [ELEM_W-1:0]   elem_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [RES_W-1:0]    result_t;

    // Opcodes, all other values are retired as no-ops
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_LOAD = 4'd1;
    localparam opcode_t OP_DOT  = 4'd2;

    // Saturation bounds of the 16-bit result
    localparam acc_t RES_MAX = 32'sd32767;
    localparam acc_t RES_MIN = -32'sd32768;

    // ====================
    // Request structs
    // ====================
    typedef struct packed {
        logic       valid;
        logic       target;   // 0 left bank, 1 right bank
        word_addr_t addr;
        op_word_t   data;
    } load_req_t;

    typedef struct packed {
        word_addr_t left;
        word_addr_t right;
        word_addr_t len_m1;   // Word count minus one
    } dot_job_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_LOAD_DATA,
        DEC_WAIT_DOT
    } dec_state_t;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_READ,
        MAC_DRAIN,
        MAC_DONE
    } mac_state_t;

endpackage : engine_pkg

`default_nettype wire
